/* ifu_aln_macros.svh */
// width and depth constants for the instruction aligner
`ifndef IFU_ALN_MACROS_SVH
`define IFU_ALN_MACROS_SVH

// fetch word as delivered in memory format
`define ALN_FETCH_W   32

// one 2-byte parcel
`define ALN_PARCEL_W  16

// halfword pc, bits 31 to 1
`define ALN_PC_W      31

// fetch buffer entries
// the modulo-3 pointers assume exactly three
`define ALN_FB_DEPTH  3

`endif

/* ifu_aln_pkg.sv */
// aligner package with width typedefs, packet structs, state enum and pointer step
`include "ifu_aln_macros.svh"

package ifu_aln_pkg;

   typedef logic [`ALN_FETCH_W-1:0]  fetch_word_t;
   typedef logic [`ALN_PARCEL_W-1:0] parcel_t;
   typedef logic [`ALN_PC_W-1:0]     hpc_t;       // pc[31:1]
   typedef logic [1:0]               pval_t;      // one bit per parcel, right justified
   typedef logic [1:0]               fb_ptr_t;    // 0..2 only

   // what fetch hands in each cycle
   typedef struct packed {
      pval_t       val;
      fetch_word_t data;
      hpc_t        pc;
      pval_t       icaf;
   } fetch_pkt_t;

   // one buffer slot after the half offset
   typedef struct packed {
      fetch_word_t data;
      hpc_t        pc;
      pval_t       icaf;
   } fb_view_t;

   // instruction 0 towards decode
   typedef struct packed {
      logic        valid;
      fetch_word_t instr;
      hpc_t        pc;
      logic        pc4;
      logic        icaf;
   } i0_pkt_t;

   typedef enum logic {
      ALN_RUN,
      ALN_ERR_STALL
   } aln_state_e;

   // modulo-3 add for buffer pointers
   function automatic fb_ptr_t fb_ptr_add(fb_ptr_t p, logic [1:0] n);
      logic [2:0] sum;
      sum = {1'b0, p} + {1'b0, n};
      if (sum >= 3'(`ALN_FB_DEPTH)) begin
         sum = sum - 3'(`ALN_FB_DEPTH);
      end
      return sum[1:0];
   endfunction

endpackage

/* aln_fill_ctl.sv */
// aligner fill FSM with slot valids, shift decisions, consume pulses and error stall
`timescale 1ns/1ns

module aln_fill_ctl (
   input  logic                clk,
   input  logic                rst_n,
   input  ifu_aln_pkg::pval_t  fetch_val,
   input  logic                async_err,
   input  logic                flush,
   input  logic                decode,
   input  logic                first_4b,
   output ifu_aln_pkg::pval_t  f0val,
   output ifu_aln_pkg::pval_t  f1val,
   output logic                f0_shift_2b,
   output logic                f1_shift_2b,
   output logic                consume1,
   output logic                consume2
);

   import ifu_aln_pkg::*;

   aln_state_e state, state_nxt;

   pval_t f2val;
   pval_t f0val_in, f1val_in, f2val_in;
   pval_t sf0val, sf1val;                   // slot valids after this cycle's shift

   logic i0_rdy;
   logic i0_shift, shift_2b, shift_4b;
   logic s0, s1, s2, wr;
   logic shift_f1_f0, shift_f2_f0, shift_f2_f1;
   logic fetch_to_f0, fetch_to_f1, fetch_to_f2;
   logic consume_fb0, consume_fb1;

   // ************************************************
   // decode side
   // ************************************************

   // all parcels of the shown instruction present
   assign i0_rdy   = first_4b ? (f0val[1] | f1val[0]) : f0val[0];

   assign i0_shift = decode & i0_rdy & (state == ALN_RUN);
   assign shift_2b = i0_shift & ~first_4b;
   assign shift_4b = i0_shift &  first_4b;

   assign f0_shift_2b = (shift_2b & f0val[0]) |
                        (shift_4b & f0val[0] & ~f0val[1]);   // 4B eats the last half of f0
   assign f1_shift_2b = shift_4b & f0val[0] & ~f0val[1];     // ...and the low half of f1

   always_comb begin
      if (shift_2b) sf0val = {1'b0, f0val[1]};
      else if (shift_4b) sf0val = '0;
      else sf0val = f0val;
   end

   assign sf1val = f1_shift_2b ? {1'b0, f1val[1]} : f1val;

   // a slot that went empty frees its buffer
   assign consume_fb0 = f0val[0] & ~sf0val[0];
   assign consume_fb1 = f1val[0] & ~sf1val[0];

   assign consume1 = consume_fb0 & ~consume_fb1 & ~flush;
   assign consume2 = consume_fb0 &  consume_fb1 & ~flush;

   // ************************************************
   // fill and compaction
   // ************************************************

   // {s0,s1,s2}: 000 if->f0 | 100 if->f1 | 010 if->f1, f1->f0
   // 110 if->f2 | 001 if->f1, f2->f0 | 011 if->f2, f2->f1, f1->f0
   assign s0 = sf0val[0];
   assign s1 = sf1val[0];
   assign s2 = f2val[0];
   assign wr = fetch_val[0];

   assign shift_f1_f0 = ~s0 &  s1;
   assign shift_f2_f0 = ~s0 & ~s1 & s2;
   assign shift_f2_f1 = ~s0 &  s1 & s2;

   assign fetch_to_f0 = wr & ~s0 & ~s1 & ~s2;
   assign fetch_to_f1 = wr & ((~s0 & ~s1 & s2) | (~s0 & s1 & ~s2) | (s0 & ~s1 & ~s2));
   assign fetch_to_f2 = wr & ((~s0 & s1 & s2) | (s0 & s1 & ~s2));

   always_comb begin
      f0val_in = '0;
      f1val_in = '0;
      f2val_in = '0;
      if (!flush) begin
         if (fetch_to_f0) f0val_in = fetch_val;
         else if (shift_f2_f0) f0val_in = f2val;
         else if (shift_f1_f0) f0val_in = sf1val;
         else f0val_in = sf0val;

         if (fetch_to_f1) f1val_in = fetch_val;
         else if (shift_f2_f1) f1val_in = f2val;
         else if (!shift_f1_f0) f1val_in = sf1val;

         if (fetch_to_f2) f2val_in = fetch_val;
         else if (!shift_f2_f1 && !shift_f2_f0) f2val_in = f2val;
      end
   end

   // ************************************************
   // error stall
   // ************************************************
   always_comb begin
      state_nxt = state;
      case (state)
         ALN_RUN:       if (async_err && !flush) state_nxt = ALN_ERR_STALL;
         ALN_ERR_STALL: if (flush) state_nxt = ALN_RUN;    // only a flush gets out
         default:       state_nxt = ALN_RUN;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         f0val <= '0;
         f1val <= '0;
         f2val <= '0;
         state <= ALN_RUN;
      end else begin
         f0val <= f0val_in;
         f1val <= f1val_in;
         f2val <= f2val_in;
         state <= state_nxt;
      end
   end

endmodule

/* fb_ptr_ctl.sv */
// fetch buffer modulo-3 write/read pointers and per-entry half-used bits
`timescale 1ns/1ns
`include "ifu_aln_macros.svh"

module fb_ptr_ctl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      wr_req,
   input  logic                      flush,
   input  logic                      consume1,
   input  logic                      consume2,
   input  logic                      f0_shift_2b,
   input  logic                      f1_shift_2b,
   output logic [`ALN_FB_DEPTH-1:0]  wen,
   output ifu_aln_pkg::fb_ptr_t      rdptr,
   output logic                      q0_hi,
   output logic                      q1_hi
);

   import ifu_aln_pkg::*;

   fb_ptr_t wrptr, wrptr_nxt;
   fb_ptr_t rdptr_nxt;
   fb_ptr_t rdptr_p1;                            // entry backing slot 1

   logic [`ALN_FB_DEPTH-1:0] half_used, half_used_nxt;

   assign rdptr_p1 = fb_ptr_add(rdptr, 2'd1);

   // one-hot write strobe at the write pointer
   always_comb begin
      wen        = '0;
      wen[wrptr] = wr_req;
   end

   // ************************************************
   // pointer counters
   // ************************************************
   always_comb begin
      if (flush) wrptr_nxt = '0;
      else if (wr_req) wrptr_nxt = fb_ptr_add(wrptr, 2'd1);
      else wrptr_nxt = wrptr;
   end

   always_comb begin
      if (flush) rdptr_nxt = '0;
      else if (consume2) rdptr_nxt = fb_ptr_add(rdptr, 2'd2);   // f0 and f1 both gone
      else if (consume1) rdptr_nxt = fb_ptr_add(rdptr, 2'd1);
      else rdptr_nxt = rdptr;
   end

   // ************************************************
   // half-used tracking
   // ************************************************

   // fresh word clears, shift of the backed slot sets
   always_comb begin
      for (int i = 0; i < `ALN_FB_DEPTH; i++) begin
         if (flush || wen[i]) begin
            half_used_nxt[i] = 1'b0;
         end else if (fb_ptr_t'(i) == rdptr) begin
            half_used_nxt[i] = half_used[i] | f0_shift_2b;
         end else if (fb_ptr_t'(i) == rdptr_p1) begin
            half_used_nxt[i] = half_used[i] | f1_shift_2b;
         end else begin
            half_used_nxt[i] = half_used[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wrptr     <= '0;
         rdptr     <= '0;
         half_used <= '0;
      end else begin
         wrptr     <= wrptr_nxt;
         rdptr     <= rdptr_nxt;
         half_used <= half_used_nxt;
      end
   end

   assign q0_hi = half_used[rdptr];
   assign q1_hi = half_used[rdptr_p1];

endmodule

/* fb_queue.sv */
// fetch buffer storage with rotated, half-offset slot views
`timescale 1ns/1ns
`include "ifu_aln_macros.svh"

module fb_queue (
   input  logic                      clk,
   input  logic                      rst_n,
   input  ifu_aln_pkg::fetch_pkt_t   fetch,
   input  logic [`ALN_FB_DEPTH-1:0]  wen,
   input  ifu_aln_pkg::fb_ptr_t      rdptr,
   input  logic                      q0_hi,
   input  logic                      q1_hi,
   output ifu_aln_pkg::fb_view_t     f0,
   output ifu_aln_pkg::fb_view_t     f1
);

   import ifu_aln_pkg::*;

   fb_view_t entry [`ALN_FB_DEPTH];
   fb_view_t wr_view;
   fb_view_t q0_raw, q1_raw;

   // drop the used low parcel and point past it
   function automatic fb_view_t half_shift(fb_view_t e, logic hi);
      fb_view_t v;
      parcel_t  upper;
      v     = e;
      upper = e.data[`ALN_FETCH_W-1 -: `ALN_PARCEL_W];
      if (hi) begin
         v.data = {{(`ALN_FETCH_W-`ALN_PARCEL_W){1'b0}}, upper};
         v.pc   = e.pc + hpc_t'(1);
         v.icaf = {1'b0, e.icaf[1]};
      end
      return v;
   endfunction

   assign wr_view = '{data: fetch.data, pc: fetch.pc, icaf: fetch.icaf};

   // ************************************************
   // entries
   // ************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `ALN_FB_DEPTH; i++) begin
            entry[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `ALN_FB_DEPTH; i++) begin
            if (wen[i]) entry[i] <= wr_view;
         end
      end
   end

   // ************************************************
   // read rotation
   // ************************************************
   assign q0_raw = entry[rdptr];                       // oldest buffer
   assign q1_raw = entry[fb_ptr_add(rdptr, 2'd1)];     // next oldest

   assign f0 = half_shift(q0_raw, q0_hi);
   assign f1 = half_shift(q1_raw, q1_hi);

endmodule

/* aln_extract.sv */
// instruction extractor with 2-byte alignment, length detect and i0 packet
`timescale 1ns/1ns
`include "ifu_aln_macros.svh"

module aln_extract (
   input  ifu_aln_pkg::fb_view_t  f0,
   input  ifu_aln_pkg::fb_view_t  f1,
   input  ifu_aln_pkg::pval_t     f0val,
   input  ifu_aln_pkg::pval_t     f1val,
   output ifu_aln_pkg::i0_pkt_t   i0,
   output logic                   first_4b
);

   import ifu_aln_pkg::*;

   parcel_t p0, p1;              // first and second parcel of i0
   pval_t   alignval;
   pval_t   alignicaf;
   logic    from_f1;             // second parcel straddles into f1
   logic    first_2b;

   assign from_f1 = ~f0val[1] & f0val[0];

   // ************************************************
   // alignment
   // ************************************************
   assign p0 = f0val[0] ? f0.data[`ALN_PARCEL_W-1:0] : '0;

   always_comb begin
      if (f0val[1]) p1 = f0.data[`ALN_FETCH_W-1 -: `ALN_PARCEL_W];
      else if (from_f1) p1 = f1.data[`ALN_PARCEL_W-1:0];
      else p1 = '0;
   end

   always_comb begin
      if (f0val[1]) begin
         alignval  = 2'b11;
         alignicaf = f0.icaf;
      end else if (from_f1) begin
         alignval  = {f1val[0], 1'b1};
         alignicaf = {f1.icaf[0], f0.icaf[0]};
      end else begin
         alignval  = '0;
         alignicaf = '0;
      end
   end

   // ************************************************
   // length and outputs
   // ************************************************
   assign first_4b = (p0[1:0] == 2'b11);     // rvc opcodes never have 11 here
   assign first_2b = ~first_4b;

   assign i0.valid = (first_4b & alignval[1]) |
                     (first_2b & alignval[0]);

   always_comb begin
      if (first_4b && alignval[1]) begin
         i0.instr = {p1, p0};
      end else if (first_2b && alignval[0]) begin
         i0.instr = {{(`ALN_FETCH_W-`ALN_PARCEL_W){1'b0}}, p0};   // raw compressed parcel
      end else begin
         i0.instr = '0;
      end
   end

   assign i0.pc  = f0.pc;
   assign i0.pc4 = first_4b;

   // a fault on any used parcel faults the instruction
   assign i0.icaf = (first_4b & (|alignicaf)) |
                    (first_2b & alignicaf[0]);

endmodule

/* ifu_aln_top.sv */
// instruction aligner top level wiring fill FSM, pointers, buffer and extractor
`timescale 1ns/1ns
`include "ifu_aln_macros.svh"

module ifu_aln_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  ifu_aln_pkg::fetch_pkt_t  fetch,
   input  logic                     async_err,
   input  logic                     flush,
   input  logic                     decode,
   output ifu_aln_pkg::i0_pkt_t     i0,
   output logic                     consume1,
   output logic                     consume2
);

   import ifu_aln_pkg::*;

   pval_t    f0val, f1val;
   logic     first_4b;
   logic     f0_shift_2b, f1_shift_2b;
   logic     q0_hi, q1_hi;
   fb_ptr_t  rdptr;
   fb_view_t f0, f1;

   logic [`ALN_FB_DEPTH-1:0] wen;

   // ************************************************
   // control
   // ************************************************
   aln_fill_ctl i_aln_fill_ctl (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_val   (fetch.val),
      .async_err   (async_err),
      .flush       (flush),
      .decode      (decode),
      .first_4b    (first_4b),
      .f0val       (f0val),
      .f1val       (f1val),
      .f0_shift_2b (f0_shift_2b),
      .f1_shift_2b (f1_shift_2b),
      .consume1    (consume1),
      .consume2    (consume2)
   );

   fb_ptr_ctl i_fb_ptr_ctl (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_req      (fetch.val[0]),        // word offered this cycle
      .flush       (flush),
      .consume1    (consume1),
      .consume2    (consume2),
      .f0_shift_2b (f0_shift_2b),
      .f1_shift_2b (f1_shift_2b),
      .wen         (wen),
      .rdptr       (rdptr),
      .q0_hi       (q0_hi),
      .q1_hi       (q1_hi)
   );

   // ************************************************
   // datapath
   // ************************************************
   fb_queue i_fb_queue (
      .clk   (clk),
      .rst_n (rst_n),
      .fetch (fetch),
      .wen   (wen),
      .rdptr (rdptr),
      .q0_hi (q0_hi),
      .q1_hi (q1_hi),
      .f0    (f0),
      .f1    (f1)
   );

   aln_extract i_aln_extract (
      .f0       (f0),
      .f1       (f1),
      .f0val    (f0val),
      .f1val    (f1val),
      .i0       (i0),
      .first_4b (first_4b)
   );

endmodule

/* tb_ifu_aln_top.sv */
// testbench for the instruction aligner, one cycle per line of the cases file
`timescale 1ns/1ns

module tb_ifu_aln_top;

   import ifu_aln_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int RST_CYCLES = 5;
   localparam int MAX_CASES  = 256;

   // one cycle of stimulus plus what the aligner should show
   typedef struct packed {
      fetch_pkt_t fetch;
      logic       decode;
      logic       flush;
      logic       async_err;
      i0_pkt_t    exp_i0;
      logic       exp_c1;
      logic       exp_c2;
   } case_t;

   logic       clk;
   logic       rst_n;
   fetch_pkt_t fetch;
   logic       async_err;
   logic       flush;
   logic       decode;
   i0_pkt_t    i0;
   logic       consume1;
   logic       consume2;

   case_t cases [MAX_CASES];
   string case_name [MAX_CASES];
   int    num_cases;
   bit    cases_loaded;

   ifu_aln_top i_ifu_aln_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .fetch     (fetch),
      .async_err (async_err),
      .flush     (flush),
      .decode    (decode),
      .i0        (i0),
      .consume1  (consume1),
      .consume2  (consume2)
   );

   // **************************************************
   // helpers
   // **************************************************
   task automatic check_value(string name, string field, logic [31:0] expected,
                              logic [31:0] actual);
      if (actual !== expected) begin
         $display("** Error: %0s %0s expected %h actual %h", name, field, expected, actual);
         $display("test failed");
         $fatal(1, "output mismatch");
      end
   endtask

   task automatic load_cases();
      int          fd;
      int          n;
      string       line;
      string       nm;
      logic [31:0] val, data, pc, icaf, dec, fl, err;
      logic [31:0] e_val, e_instr, e_pc, e_pc4, e_icaf, e_c1, e_c2;
      fd = $fopen("aln_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open the cases file aln_cases.txt");
         $display("test failed");
         $fatal(1, "no stimulus");
      end
      num_cases = 0;
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.getc(0) != "#") begin   // skip blanks and column notes
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        nm, val, data, pc, icaf, dec, fl, err,
                        e_val, e_instr, e_pc, e_pc4, e_icaf, e_c1, e_c2);
            if (n != 15 || num_cases == MAX_CASES) begin
               $display("bad or surplus line in the cases file: %0s", line);
               $display("test failed");
               $fatal(1, "cases file unreadable");
            end
            case_name[num_cases]        = nm;
            cases[num_cases].fetch      = '{val: val[1:0], data: data,
                                            pc: pc[30:0], icaf: icaf[1:0]};
            cases[num_cases].decode     = dec[0];
            cases[num_cases].flush      = fl[0];
            cases[num_cases].async_err  = err[0];
            cases[num_cases].exp_i0     = '{valid: e_val[0], instr: e_instr,
                                            pc: e_pc[30:0], pc4: e_pc4[0],
                                            icaf: e_icaf[0]};
            cases[num_cases].exp_c1     = e_c1[0];
            cases[num_cases].exp_c2     = e_c2[0];
            num_cases++;
         end
      end
      $fclose(fd);
      if (num_cases == 0) begin
         $display("the cases file holds no cases");
         $display("test failed");
         $fatal(1, "empty stimulus");
      end
      cases_loaded = 1'b1;
   endtask

   // instruction fields only matter while valid is expected
   task automatic verify_outputs(int k);
      case_t c;
      string tag;
      c   = cases[k];
      tag = $sformatf("%0s[%0d]", case_name[k], k);
      check_value(tag, "valid", 32'(c.exp_i0.valid), 32'(i0.valid));
      check_value(tag, "consume1", 32'(c.exp_c1), 32'(consume1));
      check_value(tag, "consume2", 32'(c.exp_c2), 32'(consume2));
      if (c.exp_i0.valid) begin
         check_value(tag, "instr", c.exp_i0.instr, i0.instr);
         check_value(tag, "pc", 32'(c.exp_i0.pc), 32'(i0.pc));
         check_value(tag, "pc4", 32'(c.exp_i0.pc4), 32'(i0.pc4));
         check_value(tag, "icaf", 32'(c.exp_i0.icaf), 32'(i0.icaf));
      end
   endtask

   // **************************************************
   // clock, watchdog, main sequence
   // **************************************************
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      wait (cases_loaded);
      #((num_cases + RST_CYCLES + 20) * CLK_PERIOD);   // every line is one cycle
      $display("watchdog expired before all cases were run");
      $display("test failed");
      $fatal(1, "timeout");
   end

   initial begin
      rst_n     = 1'b0;
      fetch     = '0;
      async_err = 1'b0;
      flush     = 1'b0;
      decode    = 1'b0;
      load_cases();
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int k = 0; k < num_cases; k++) begin
         @(posedge clk);
         fetch     <= cases[k].fetch;
         decode    <= cases[k].decode;
         flush     <= cases[k].flush;
         async_err <= cases[k].async_err;
         @(negedge clk);                      // outputs settled mid cycle
         verify_outputs(k);
      end
      $display("test passed");
      $finish;
   end

endmodule

/* ifu_aln_top.f */
+incdir+.
ifu_aln_pkg.sv
aln_fill_ctl.sv
fb_ptr_ctl.sv
fb_queue.sv
aln_extract.sv
ifu_aln_top.sv
tb_ifu_aln_top.sv

/* Makefile */
# Verilator build and run of the instruction aligner testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run tb_ifu_aln_top, exit status gives the result"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ns -f ifu_aln_top.f \
		--top-module tb_ifu_aln_top
	./obj_dir/Vtb_ifu_aln_top

clean:
	rm -rf obj_dir

/* aln_cases.txt */
# name val data pc icaf decode flush async_err  exp: valid instr pc pc4 icaf consume1 consume2
# all hex, pc is the halfword pc (byte address >> 1), inputs and outputs belong to one cycle
reset_idle  0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
two_2b      3 45854501 80  0 0 0 0  0 00000000 0   0 0 0 0
two_2b      0 00000000 0   0 1 0 0  1 00004501 80  0 0 0 0
two_2b      0 00000000 0   0 1 0 0  1 00004585 81  0 0 1 0
two_2b      0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
straddle_4b 3 00934501 90  0 0 0 0  0 00000000 0   0 0 0 0
straddle_4b 3 460500a0 92  0 1 0 0  1 00004501 90  0 0 0 0
straddle_4b 0 00000000 0   0 1 0 0  1 00a00093 91  1 0 1 0
straddle_4b 0 00000000 0   0 1 0 0  1 00004605 93  0 0 1 0
straddle_4b 0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
consume2    3 01134501 a0  0 0 0 0  0 00000000 0   0 0 0 0
consume2    1 dead00b0 a2  0 1 0 0  1 00004501 a0  0 0 0 0
consume2    0 00000000 0   0 1 0 0  1 00b00113 a1  1 0 0 1
consume2    0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
fault_4b    3 00c00193 b0  2 0 0 0  0 00000000 0   0 0 0 0
fault_4b    0 00000000 0   0 1 0 0  1 00c00193 b0  1 1 1 0
fault_4b    0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
fault_2b    3 46054501 c0  2 0 0 0  0 00000000 0   0 0 0 0
fault_2b    0 00000000 0   0 1 0 0  1 00004501 c0  0 0 0 0
fault_2b    0 00000000 0   0 0 0 0  1 00004605 c1  0 1 0 0
flush       0 00000000 0   0 1 1 0  1 00004605 c1  0 1 0 0
flush       3 00d00213 100 0 0 0 0  0 00000000 0   0 0 0 0
flush       0 00000000 0   0 1 0 0  1 00d00213 100 1 0 1 0
flush       0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
err_stall   3 45854501 110 0 0 0 0  0 00000000 0   0 0 0 0
err_stall   0 00000000 0   0 0 0 1  1 00004501 110 0 0 0 0
err_stall   0 00000000 0   0 1 0 0  1 00004501 110 0 0 0 0
err_stall   0 00000000 0   0 1 0 0  1 00004501 110 0 0 0 0
err_stall   0 00000000 0   0 1 1 0  1 00004501 110 0 0 0 0
err_stall   0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
recover     3 45854501 120 0 0 0 0  0 00000000 0   0 0 0 0
recover     0 00000000 0   0 1 0 0  1 00004501 120 0 0 0 0
recover     0 00000000 0   0 1 0 0  1 00004585 121 0 0 1 0
recover     0 00000000 0   0 0 0 0  0 00000000 0   0 0 0 0
